/* Bender.yml */
package:
  name: mips_core

sources:
  # packages first, isa before core
  - mipsIsaPkg.sv
  - mipsCorePkg.sv
  # datapath blocks
  - mipsDecoder.sv
  - mipsAlu.sv
  - mipsRegFile.sv
  - mipsPcUnit.sv
  # top level
  - mipsCore.sv
  - target: test
    files:
      - mipsCoreTb.sv

/* files.f */
mipsIsaPkg.sv
mipsCorePkg.sv
mipsDecoder.sv
mipsAlu.sv
mipsRegFile.sv
mipsPcUnit.sv
mipsCore.sv
mipsCoreTb.sv

/* mipsAlu.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsAlu
  import mipsCorePkg::*;
(
  input  wordT  a,
  input  wordT  b,
  input  aluOpT aluOp,
  output wordT  result,
  output logic  zero
);

  // ========================================
  // operation select
  // ========================================

  always_comb begin
    case (aluOp)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluSlt: begin
        // two's complement compare
        if ($signed(a) < $signed(b)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      // aluNone and anything unused
      default: result = '0;
    endcase
  end

  // flag on every op, only beq looks at it
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCore
  import mipsIsaPkg::*;
  import mipsCorePkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  instrT   instr,
  input  wordT    dataRead,
  output wordT    instrAddr,
  output memAddrT dataAddr,
  output wordT    dataWrite,
  output logic    dataCen,
  output logic    dataWen,
  output logic    wbEn,
  output regNumT  wbAddr,
  output wordT    wbData
);

  // instruction fields
  opcodeT    opcode;
  regNumT    rs;
  regNumT    rt;
  regNumT    rd;
  functT     funct;
  imm16T     imm;
  jumpIndexT jumpIndex;

  // decoder controls
  logic  regDst;
  logic  aluSrc;
  logic  memToReg;
  logic  regWrite;
  logic  memRead;
  logic  memWrite;
  logic  branch;
  logic  jump;
  logic  link;
  logic  jumpReg;
  aluOpT aluOp;

  // datapath
  wordT  immExt;
  wordT  readDataA;
  wordT  readDataB;
  wordT  aluB;
  wordT  aluResult;
  logic  aluZero;
  wordT  pc;
  wordT  pcLink;
  logic  regWriteRun;

  // ========================================
  // field split
  // ========================================

  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign funct     = instr[5:0];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];

  // sign extension for lw/sw offset
  assign immExt = {{16{imm[15]}}, imm};

  mipsDecoder decoder (
    .opcode   (opcode),
    .funct    (funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .jumpReg  (jumpReg),
    .aluOp    (aluOp)
  );

  // ========================================
  // register file and write-back
  // ========================================

  // rt for lw, rd for r-type, r31 on jal
  assign wbAddr = link ? regLink : (regDst ? rd : rt);

  // link wins, then memory, then alu
  assign wbData = link ? pcLink : (memToReg ? dataRead : aluResult);

  // no register writes while rst is low
  assign regWriteRun = regWrite & rst;

  mipsRegFile regFile (
    .clk        (clk),
    .rst        (rst),
    .writeEn    (regWriteRun),
    .readAddrA  (rs),
    .readAddrB  (rt),
    .writeAddr  (wbAddr),
    .writeData  (wbData),
    .readDataA  (readDataA),
    .readDataB  (readDataB),
    .writeTaken (wbEn)
  );

  // ========================================
  // execute
  // ========================================

  assign aluB = aluSrc ? immExt : readDataB;

  mipsAlu alu (
    .a      (readDataA),
    .b      (aluB),
    .aluOp  (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // jr target is rs
  mipsPcUnit pcUnit (
    .clk        (clk),
    .rst        (rst),
    .branch     (branch),
    .zero       (aluZero),
    .jump       (jump),
    .jumpReg    (jumpReg),
    .imm        (imm),
    .jumpIndex  (jumpIndex),
    .jumpTarget (readDataA),
    .pc         (pc),
    .pcLink     (pcLink)
  );

  assign instrAddr = pc;

  // ========================================
  // data memory port
  // ========================================

  // word address from byte address
  assign dataAddr  = aluResult[8:2];
  assign dataWrite = readDataB;

  // active-low strobes, both idle in reset
  assign dataCen = ~((memRead | memWrite) & rst);
  assign dataWen = ~(memWrite & rst);

endmodule

`default_nettype wire

/* mipsCorePkg.sv */
`default_nettype none

package mipsCorePkg;

  // register numbers come from the isa side
  import mipsIsaPkg::*;

  // ========================================
  // datapath widths
  // ========================================

  localparam int wordWidth    = 32;
  // 128-word data memory
  localparam int memAddrWidth = 7;

  // data word, also used for byte addresses
  typedef logic [wordWidth-1:0] wordT;

  // word address into data memory
  typedef logic [memAddrWidth-1:0] memAddrT;

  // ========================================
  // alu operation codes
  // ========================================

  typedef logic [2:0] aluOpT;

  localparam aluOpT aluAdd  = 3'd0;
  localparam aluOpT aluSub  = 3'd1;
  localparam aluOpT aluAnd  = 3'd2;
  localparam aluOpT aluOr   = 3'd3;
  localparam aluOpT aluSlt  = 3'd4;
  // unknown or unused op, result forced to zero
  localparam aluOpT aluNone = 3'd7;

  // ========================================
  // fixed register numbers
  // ========================================

  // jal return address
  localparam regNumT regLink = 5'd31;
  // hard-wired zero
  localparam regNumT regZero = 5'd0;

endpackage

`default_nettype wire

/* mipsCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb
  import mipsIsaPkg::*;
  import mipsCorePkg::*;
();

  localparam int clkPeriod = 40;
  // sample point after the falling edge
  localparam int settle = 5;
  // instruction counts of arith, ldst, beq, jumps, r0 and random
  localparam int programCycles = 11 + 9 + 9 + 9 + 5 + 31;
  localparam int resetCycles = 6 * 8;
  localparam int watchdogTime = (programCycles + resetCycles + 40) * clkPeriod;

  logic    clk = 1'b0;
  logic    rst;
  instrT   instr;
  wordT    dataRead;
  wordT    instrAddr;
  memAddrT dataAddr;
  wordT    dataWrite;
  logic    dataCen;
  logic    dataWen;
  logic    wbEn;
  regNumT  wbAddr;
  wordT    wbData;

  // memory models
  instrT imem [0:63];
  wordT  dmem [0:127];

  // reference model state
  wordT refRegs [0:31];
  wordT refMem [0:127];
  wordT refPc;
  // last value seen on the write-back port per register
  wordT dutRegs [0:31];

  int     errors;
  int     checkCount;
  integer seed;

  always #(clkPeriod / 2) clk = ~clk;

  mipsCore UUT (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .dataRead  (dataRead),
    .instrAddr (instrAddr),
    .dataAddr  (dataAddr),
    .dataWrite (dataWrite),
    .dataCen   (dataCen),
    .dataWen   (dataWen),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  // ========================================
  // memories
  // ========================================

  // 64-word program space
  assign instr = imem[instrAddr[7:2]];

  // reads only while selected
  assign dataRead = dataCen ? '0 : dmem[dataAddr];

  always @(posedge clk) begin
    if (!dataCen && !dataWen) begin
      dmem[dataAddr] <= dataWrite;
    end
  end

  // ========================================
  // compare tasks
  // ========================================

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkReg(input string name, input regNumT got, input regNumT exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkMemAddr(input string name, input memAddrT got, input memAddrT exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkMem(input memAddrT addr, input wordT got, input wordT exp);
    checkCount++;
    if (got !== exp) begin
      $display("Error dmem[%h]: got %h, expected %h", addr, got, exp);
      errors++;
    end
  endtask

  // ========================================
  // assembler helpers
  // ========================================

  function automatic instrT rInstr(input functT fn, input regNumT rd, input regNumT rs,
                                   input regNumT rt);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic instrT iInstr(input opcodeT op, input regNumT rt, input regNumT rs,
                                   input imm16T imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic instrT jInstr(input opcodeT op, input jumpIndexT index);
    return {op, index};
  endfunction

  // preset a data word in both memories
  task automatic setMem(input memAddrT addr, input wordT value);
    dmem[addr] = value;
    refMem[addr] = value;
  endtask

  task automatic compareMemory();
    for (int i = 0; i < 128; i++) begin
      checkMem(memAddrT'(i), dmem[i], refMem[i]);
    end
  endtask

  // ========================================
  // reset sequence
  // ========================================

  task automatic checkResetState();
    checkWord("instrAddr", instrAddr, 32'h0);
    checkFlag("dataCen", dataCen, 1'b1);
    checkFlag("dataWen", dataWen, 1'b1);
    checkFlag("wbEn", wbEn, 1'b0);
  endtask

  // runs on a falling edge and leaves rst low while the test loads imem
  task automatic enterReset();
    rst = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    // a store at word 0 would strobe memory if reset let it through
    imem[0] = iInstr(opSw, 5'd0, 5'd0, 16'd0);
    #settle;
    checkResetState();
  endtask

  task automatic leaveReset();
    repeat (7) begin
      @(negedge clk);
      #settle;
      checkResetState();
    end
    @(negedge clk);
    rst = 1'b1;
    refPc = '0;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
      dutRegs[i] = '0;
    end
  endtask

  // ========================================
  // reference model, one instruction
  // ========================================

  task automatic stepAndCompare();
    instrT   w;
    opcodeT  op;
    functT   fn;
    regNumT  rs;
    regNumT  rt;
    wordT    a;
    wordT    b;
    wordT    sext;
    wordT    pc4;
    wordT    nextPc;
    wordT    result;
    wordT    expData;
    regNumT  expAddr;
    memAddrT memAddr;
    logic    expWb;
    logic    memRd;
    logic    memWr;
    #settle;
    w = imem[refPc[7:2]];
    op = w[31:26];
    rs = w[25:21];
    rt = w[20:16];
    fn = w[5:0];
    a = refRegs[rs];
    b = refRegs[rt];
    sext = {{16{w[15]}}, w[15:0]};
    pc4 = refPc + 32'd4;
    nextPc = pc4;
    expWb = 1'b0;
    expAddr = w[15:11];
    expData = '0;
    memRd = 1'b0;
    memWr = 1'b0;
    // word address from bits 8..2 of base plus offset
    memAddr = memAddrT'((a + sext) >> 2);
    case (op)
      opRType: begin
        case (fn)
          fnAdd:   result = a + b;
          fnSub:   result = a - b;
          fnAnd:   result = a & b;
          fnOr:    result = a | b;
          fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: result = '0;
        endcase
        if (fn == fnJr) begin
          nextPc = a;
        end else begin
          expWb = 1'b1;
          expData = result;
        end
      end
      opLw: begin
        memRd = 1'b1;
        expWb = 1'b1;
        expAddr = rt;
        expData = refMem[memAddr];
      end
      opSw: begin
        memWr = 1'b1;
      end
      opBeq: begin
        if (a == b) begin
          nextPc = pc4 + {sext[29:0], 2'b00};
        end
      end
      opJ: begin
        nextPc = {pc4[31:28], w[25:0], 2'b00};
      end
      opJal: begin
        nextPc = {pc4[31:28], w[25:0], 2'b00};
        expWb = 1'b1;
        expAddr = regLink;
        expData = refPc + 32'd8;
      end
      default: begin
      end
    endcase
    // r0 never retires a write
    if (expAddr == regZero) begin
      expWb = 1'b0;
    end

    checkWord("instrAddr", instrAddr, refPc);
    checkFlag("dataCen", dataCen, ~(memRd | memWr));
    checkFlag("dataWen", dataWen, ~memWr);
    if (memRd || memWr) begin
      checkMemAddr("dataAddr", dataAddr, memAddr);
    end
    if (memWr) begin
      checkWord("dataWrite", dataWrite, b);
    end
    if (expWb && !wbEn) begin
      $display("write-back to register %0d missing at pc %h", expAddr, refPc);
      errors++;
    end else if (!expWb && wbEn) begin
      $display("unexpected write-back to register %0d at pc %h", wbAddr, refPc);
      errors++;
    end else if (expWb) begin
      checkReg("wbAddr", wbAddr, expAddr);
      checkWord("wbData", wbData, expData);
    end

    // commit lines up with the rising edge
    if (wbEn) begin
      dutRegs[wbAddr] = wbData;
    end
    if (expWb) begin
      refRegs[expAddr] = expData;
    end
    if (memWr) begin
      refMem[memAddr] = b;
    end
    refPc = nextPc;
    @(negedge clk);
  endtask

  task automatic runInstructions(input int count);
    repeat (count) begin
      stepAndCompare();
    end
  endtask

  // ========================================
  // directed tests
  // ========================================

  task automatic testArith();
    enterReset();
    setMem(7'd0, 32'h0000_0015);
    setMem(7'd1, 32'h0000_0007);
    setMem(7'd2, 32'hFFFF_FFF0);
    setMem(7'd3, 32'h0F0F_00FF);
    imem[0] = iInstr(opLw, 5'd1, 5'd0, 16'd0);
    imem[1] = iInstr(opLw, 5'd2, 5'd0, 16'd4);
    imem[2] = iInstr(opLw, 5'd3, 5'd0, 16'd8);
    imem[3] = iInstr(opLw, 5'd4, 5'd0, 16'd12);
    imem[4] = rInstr(fnAdd, 5'd5, 5'd1, 5'd2);
    imem[5] = rInstr(fnSub, 5'd6, 5'd2, 5'd1);
    imem[6] = rInstr(fnAnd, 5'd7, 5'd4, 5'd1);
    imem[7] = rInstr(fnOr, 5'd8, 5'd4, 5'd3);
    // signed compares with negative operands
    imem[8] = rInstr(fnSlt, 5'd9, 5'd3, 5'd2);
    imem[9] = rInstr(fnSlt, 5'd10, 5'd2, 5'd3);
    imem[10] = rInstr(fnSlt, 5'd11, 5'd3, 5'd6);
    leaveReset();
    runInstructions(11);
    checkWord("r5", dutRegs[5], 32'h0000_001C);
    checkWord("r6", dutRegs[6], 32'hFFFF_FFF2);
    checkWord("r7", dutRegs[7], 32'h0000_0015);
    checkWord("r8", dutRegs[8], 32'hFFFF_FFFF);
    checkWord("r9", dutRegs[9], 32'h0000_0001);
    checkWord("r11", dutRegs[11], 32'h0000_0001);
    compareMemory();
  endtask

  task automatic testLoadStore();
    enterReset();
    setMem(7'd0, 32'h0000_0015);
    setMem(7'd2, 32'hFFFF_FFF0);
    setMem(7'd4, 32'h0000_0080);
    imem[0] = iInstr(opLw, 5'd1, 5'd0, 16'd0);
    imem[1] = iInstr(opLw, 5'd3, 5'd0, 16'd8);
    imem[2] = iInstr(opLw, 5'd5, 5'd0, 16'd16);
    // negative offset lands on word 30
    imem[3] = iInstr(opSw, 5'd1, 5'd5, 16'hFFF8);
    // 0x204 wraps onto word 1
    imem[4] = iInstr(opSw, 5'd3, 5'd5, 16'h0184);
    imem[5] = iInstr(opLw, 5'd6, 5'd0, 16'd120);
    imem[6] = iInstr(opLw, 5'd7, 5'd0, 16'd4);
    imem[7] = iInstr(opSw, 5'd0, 5'd0, 16'd124);
    imem[8] = iInstr(opLw, 5'd8, 5'd0, 16'd124);
    leaveReset();
    runInstructions(9);
    checkMem(7'd30, dmem[30], 32'h0000_0015);
    checkMem(7'd1, dmem[1], 32'hFFFF_FFF0);
    checkMem(7'd31, dmem[31], 32'h0000_0000);
    checkWord("r6", dutRegs[6], 32'h0000_0015);
    checkWord("r7", dutRegs[7], 32'hFFFF_FFF0);
    compareMemory();
  endtask

  task automatic testBranch();
    enterReset();
    setMem(7'd0, 32'h0000_0015);
    imem[0] = iInstr(opLw, 5'd1, 5'd0, 16'd0);
    imem[1] = iInstr(opLw, 5'd2, 5'd0, 16'd0);
    // taken branch lands on word 6
    imem[2] = iInstr(opBeq, 5'd2, 5'd1, 16'd3);
    for (int i = 3; i < 6; i++) begin
      imem[i] = rInstr(fnAdd, 5'd3, 5'd1, 5'd1);
    end
    // not taken
    imem[6] = iInstr(opBeq, 5'd0, 5'd1, 16'd5);
    // taken branch lands on word 11
    imem[7] = iInstr(opBeq, 5'd1, 5'd2, 16'd3);
    for (int i = 8; i < 11; i++) begin
      imem[i] = rInstr(fnAdd, 5'd3, 5'd1, 5'd1);
    end
    imem[11] = rInstr(fnAdd, 5'd4, 5'd1, 5'd2);
    // backward to address zero
    imem[12] = iInstr(opBeq, 5'd0, 5'd0, 16'hFFF3);
    leaveReset();
    runInstructions(9);
    checkWord("r3", dutRegs[3], 32'h0000_0000);
    checkWord("r4", dutRegs[4], 32'h0000_002A);
    compareMemory();
  endtask

  task automatic testJumps();
    enterReset();
    setMem(7'd0, 32'h0000_0040);
    imem[0] = iInstr(opLw, 5'd1, 5'd0, 16'd0);
    // call word 8 with link 12
    imem[1] = jInstr(opJal, 26'd8);
    imem[3] = rInstr(fnJr, 5'd0, 5'd1, 5'd0);
    imem[8] = rInstr(fnAdd, 5'd2, 5'd1, 5'd1);
    imem[9] = rInstr(fnJr, 5'd0, 5'd31, 5'd0);
    imem[16] = jInstr(opJ, 26'd20);
    imem[20] = rInstr(fnOr, 5'd3, 5'd2, 5'd1);
    imem[21] = jInstr(opJ, 26'd0);
    leaveReset();
    runInstructions(9);
    checkWord("r31", dutRegs[31], 32'h0000_000C);
    checkWord("r2", dutRegs[2], 32'h0000_0080);
    checkWord("r3", dutRegs[3], 32'h0000_00C0);
    compareMemory();
  endtask

  task automatic testRegZero();
    enterReset();
    setMem(7'd0, 32'h1234_5678);
    imem[0] = iInstr(opLw, 5'd1, 5'd0, 16'd0);
    // both writes to r0 must be dropped
    imem[1] = iInstr(opLw, 5'd0, 5'd0, 16'd0);
    imem[2] = rInstr(fnAdd, 5'd0, 5'd1, 5'd1);
    imem[3] = rInstr(fnOr, 5'd2, 5'd0, 5'd1);
    imem[4] = rInstr(fnAdd, 5'd3, 5'd0, 5'd0);
    leaveReset();
    runInstructions(5);
    checkWord("r2", dutRegs[2], 32'h1234_5678);
    compareMemory();
  endtask

  task automatic testRandomArith();
    functT fns [0:4];
    int    pick;
    fns = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
    enterReset();
    for (int i = 0; i < 8; i++) begin
      setMem(memAddrT'(i), wordT'($random(seed)));
    end
    // r1..r7 from words 1..7
    for (int i = 1; i < 8; i++) begin
      imem[i - 1] = iInstr(opLw, regNumT'(i), 5'd0, imm16T'(i * 4));
    end
    for (int i = 7; i < 31; i++) begin
      pick = $unsigned($random(seed)) % 5;
      imem[i] = rInstr(fns[pick], regNumT'($unsigned($random(seed)) % 16),
                       regNumT'($unsigned($random(seed)) % 16),
                       regNumT'($unsigned($random(seed)) % 16));
    end
    leaveReset();
    runInstructions(31);
    compareMemory();
  endtask

  // ========================================
  // run control
  // ========================================

  initial begin
    rst = 1'b0;
    errors = 0;
    checkCount = 0;
    seed = 32'h0105_dc77;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    // fill differs in every address bit
    for (int i = 0; i < 128; i++) begin
      dmem[i] = wordT'(32'hC0DE_0000 ^ (i * 32'h0001_0103));
      refMem[i] = dmem[i];
    end
    testArith();
    testLoadStore();
    testBranch();
    testJumps();
    testRegZero();
    testRandomArith();
    $display("%0d checks, %0d errors", checkCount, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdogTime);
    $display("simulation timed out after %0d ns", watchdogTime);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* mipsDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsDecoder
  import mipsIsaPkg::*;
  import mipsCorePkg::*;
(
  input  opcodeT opcode,
  input  functT  funct,
  output logic   regDst,
  output logic   aluSrc,
  output logic   memToReg,
  output logic   regWrite,
  output logic   memRead,
  output logic   memWrite,
  output logic   branch,
  output logic   jump,
  output logic   link,
  output logic   jumpReg,
  output aluOpT  aluOp
);

  // ========================================
  // main control
  // ========================================

  always_comb begin
    // defaults describe a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    jumpReg  = 1'b0;
    aluOp    = aluNone;

    case (opcode)
      opRType: begin
        // destination in rd
        regDst = 1'b1;
        // jr only steers the pc
        if (funct == fnJr) begin
          jumpReg = 1'b1;
        end else begin
          regWrite = 1'b1;
        end
        // alu control from funct
        case (funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          default: aluOp = aluNone;
        endcase
      end
      opLw: begin
        // base plus offset, result from memory
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        aluOp    = aluAdd;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = aluAdd;
      end
      opBeq: begin
        // equal when rs - rt is zero
        branch = 1'b1;
        aluOp  = aluSub;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // link value and r31 picked in the core
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unsupported opcode, nothing happens
      end
    endcase
  end

endmodule

`default_nettype wire

/* mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

  // ========================================
  // instruction word and field types
  // ========================================

  // one full instruction as fetched
  typedef logic [31:0] instrT;

  // primary opcode, bits 31..26
  typedef logic [5:0] opcodeT;

  // r-type function field, bits 5..0
  typedef logic [5:0] functT;

  // rs / rt / rd register numbers
  typedef logic [4:0] regNumT;

  // i-type immediate, bits 15..0
  typedef logic [15:0] imm16T;

  // j-type target index, bits 25..0
  typedef logic [25:0] jumpIndexT;

  // ========================================
  // primary opcodes
  // ========================================

  // all r-type share opcode zero, funct picks the op
  localparam opcodeT opRType = 6'd0;
  localparam opcodeT opJ     = 6'd2;
  // jump and link, return address into r31
  localparam opcodeT opJal   = 6'd3;
  localparam opcodeT opBeq   = 6'd4;
  localparam opcodeT opLw    = 6'd35;
  localparam opcodeT opSw    = 6'd43;

  // ========================================
  // r-type function codes
  // ========================================

  // jump register, no write-back
  localparam functT fnJr  = 6'd8;
  localparam functT fnAdd = 6'd32;
  localparam functT fnSub = 6'd34;
  localparam functT fnAnd = 6'd36;
  localparam functT fnOr  = 6'd37;
  // signed set-less-than
  localparam functT fnSlt = 6'd42;

endpackage

`default_nettype wire

/* mipsPcUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsPcUnit
  import mipsIsaPkg::*;
  import mipsCorePkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      branch,
  input  logic      zero,
  input  logic      jump,
  input  logic      jumpReg,
  input  imm16T     imm,
  input  jumpIndexT jumpIndex,
  input  wordT      jumpTarget,
  output wordT      pc,
  output wordT      pcLink
);

  wordT pcPlus4;
  wordT branchAddr;
  wordT jumpAddr;
  wordT pcNext;

  // ========================================
  // candidate addresses
  // ========================================

  assign pcPlus4 = pc + 32'd4;

  // return address for jal
  assign pcLink = pc + 32'd8;

  // sign-extended word offset from pc+4
  assign branchAddr = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

  // pseudo-direct, keeps the pc+4 region
  assign jumpAddr = {pcPlus4[31:28], jumpIndex, 2'b00};

  // ========================================
  // next-pc priority and register
  // ========================================

  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (branch && zero) begin
      pcNext = branchAddr;
    end else if (jumpReg) begin
      pcNext = jumpTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // fetch restarts at address zero
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

/* mipsRegFile.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsRegFile
  import mipsIsaPkg::*;
  import mipsCorePkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   writeEn,
  input  regNumT readAddrA,
  input  regNumT readAddrB,
  input  regNumT writeAddr,
  input  wordT   writeData,
  output wordT   readDataA,
  output wordT   readDataB,
  output logic   writeTaken
);

  // 32 general purpose registers
  wordT regs [0:31];

  // ========================================
  // write port
  // ========================================

  // r0 never takes a write
  assign writeTaken = writeEn && (writeAddr != regZero);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // clear whole file
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeTaken) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ========================================
  // read ports
  // ========================================

  // combinational, r0 reads zero
  assign readDataA = (readAddrA == regZero) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == regZero) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire
